/* logic/cdc_stream_pkg.sv */
`default_nettype none

package cdc_stream_pkg;

    // beat width on both sides
    localparam int CDC_DATA_WIDTH = 32;

    // fifo entries, power of two and at least 4
    localparam int CDC_FIFO_DEPTH = 8;

    // flops in each synchronizer chain
    localparam int CDC_SYNC_STAGES = 2;

    // fill level needs one bit more than the address to tell full from empty
    localparam int CDC_LEVEL_WIDTH = $clog2(CDC_FIFO_DEPTH) + 1;

    // accepted beat counter, wraps
    localparam int CDC_COUNT_WIDTH = 16;

endpackage : cdc_stream_pkg

`default_nettype wire

/* logic/cdc_sync_bits.sv */
`default_nettype none

module cdc_sync_bits #(
    parameter int WIDTH  = 1,
    parameter int STAGES = cdc_stream_pkg::CDC_SYNC_STAGES
) (
    input  wire logic             i_clk,
    input  wire logic             i_arst_n,
    input  wire logic [WIDTH-1:0] i_d,
    output logic      [WIDTH-1:0] o_q
);

    // stage 0 is the capture flop, may go metastable
    logic [STAGES-1:0][WIDTH-1:0] sync_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= i_d;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i - 1];
            end
        end
    end

    assign o_q = sync_q[STAGES-1];  // last stage is safe to use

endmodule : cdc_sync_bits

`default_nettype wire

/* logic/fifo_axi_async.sv */
`default_nettype none

module fifo_axi_async #(
    parameter int DATA_WIDTH = cdc_stream_pkg::CDC_DATA_WIDTH,
    parameter int DEPTH      = cdc_stream_pkg::CDC_FIFO_DEPTH
) (
    // clocks and resets, one pair per domain
    input  wire logic                   i_axi_wr_aclk,
    input  wire logic                   i_axi_wr_aresetn,
    input  wire logic                   i_axi_rd_aclk,
    input  wire logic                   i_axi_rd_aresetn,

    // write side
    input  wire logic                   i_wr_valid,
    output logic                        o_wr_ready,  // not full
    input  wire logic [DATA_WIDTH-1:0]  i_wr_data,

    // read side
    input  wire logic                   i_rd_ready,
    output logic                        o_rd_valid,  // not empty
    output logic      [DATA_WIDTH-1:0]  o_rd_data,

    // fill level seen from the write domain
    output logic      [$clog2(DEPTH):0] o_wr_level
);

    import cdc_stream_pkg::*;

    localparam int AW = $clog2(DEPTH);
    // full when the two top gray bits differ and the rest match
    localparam logic [AW:0] FULL_MASK = {2'b11, {(AW - 1){1'b0}}};

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    logic          wr_fire;
    logic [AW:0]   wr_bin;
    logic [AW:0]   wr_bin_next;
    logic [AW:0]   wr_gray;
    logic [AW:0]   wr_gray_next;
    logic [AW:0]   rd_gray_sync;  // read pointer in the write domain
    logic [AW:0]   rd_bin_sync;

    logic          rd_fire;
    logic [AW:0]   rd_bin;
    logic [AW:0]   rd_bin_next;
    logic [AW:0]   rd_gray;
    logic [AW:0]   rd_gray_next;
    logic [AW:0]   wr_gray_sync;  // write pointer in the read domain

    function automatic logic [AW:0] bin_to_gray(input logic [AW:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [AW:0] gray_to_bin(input logic [AW:0] g);
        logic [AW:0] b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // write domain
    assign wr_fire      = i_wr_valid && o_wr_ready;
    assign wr_bin_next  = wr_bin + {{AW{1'b0}}, wr_fire};
    assign wr_gray_next = bin_to_gray(wr_bin_next);

    always_ff @(posedge i_axi_wr_aclk or negedge i_axi_wr_aresetn) begin
        if (!i_axi_wr_aresetn) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            o_wr_ready <= 1'b0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            // look ahead so the beat that fills the last slot drops ready at once
            o_wr_ready <= (wr_gray_next != (rd_gray_sync ^ FULL_MASK));
        end
    end

    always_ff @(posedge i_axi_wr_aclk) begin
        if (wr_fire) begin
            mem[wr_bin[AW-1:0]] <= i_wr_data;
        end
    end

    cdc_sync_bits #(
        .WIDTH  (AW + 1),
        .STAGES (CDC_SYNC_STAGES)
    ) u_rd_ptr_sync (
        .i_clk    (i_axi_wr_aclk),
        .i_arst_n (i_axi_wr_aresetn),
        .i_d      (rd_gray),
        .o_q      (rd_gray_sync)
    );

    assign rd_bin_sync = gray_to_bin(rd_gray_sync);
    assign o_wr_level  = wr_bin - rd_bin_sync;  // pessimistic, read side may be ahead

    // read domain
    assign rd_fire      = o_rd_valid && i_rd_ready;
    assign rd_bin_next  = rd_bin + {{AW{1'b0}}, rd_fire};
    assign rd_gray_next = bin_to_gray(rd_bin_next);

    always_ff @(posedge i_axi_rd_aclk or negedge i_axi_rd_aresetn) begin
        if (!i_axi_rd_aresetn) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_gray_next;
            o_rd_valid <= (rd_gray_next != wr_gray_sync);  // exact match means empty
        end
    end

    cdc_sync_bits #(
        .WIDTH  (AW + 1),
        .STAGES (CDC_SYNC_STAGES)
    ) u_wr_ptr_sync (
        .i_clk    (i_axi_rd_aclk),
        .i_arst_n (i_axi_rd_aresetn),
        .i_d      (wr_gray),
        .o_q      (wr_gray_sync)
    );

    // entry is stable long before its pointer crosses over
    assign o_rd_data = mem[rd_bin[AW-1:0]];

endmodule : fifo_axi_async

`default_nettype wire

/* logic/axi_skid_buffer_async.sv */
`default_nettype none

module axi_skid_buffer_async #(
    parameter int DATA_WIDTH = cdc_stream_pkg::CDC_DATA_WIDTH,
    parameter int DEPTH      = cdc_stream_pkg::CDC_FIFO_DEPTH
) (
    input  wire logic                   i_axi_wr_aclk,
    input  wire logic                   i_axi_wr_aresetn,
    input  wire logic                   i_axi_rd_aclk,
    input  wire logic                   i_axi_rd_aresetn,

    // input side
    input  wire logic                   i_wr_valid,
    output logic                        o_wr_ready,
    input  wire logic [DATA_WIDTH-1:0]  i_wr_data,

    // output side, all from flops
    output logic                        o_rd_valid,
    input  wire logic                   i_rd_ready,
    output logic      [DATA_WIDTH-1:0]  o_rd_data,

    output logic      [$clog2(DEPTH):0] o_wr_level
);

    logic                  fifo_rd_ready;  // registered read request
    logic                  fifo_rd_valid;
    logic [DATA_WIDTH-1:0] fifo_rd_data;
    logic                  fifo_take;
    logic                  out_take;

    logic                  main_valid;
    logic                  main_valid_d;
    logic [DATA_WIDTH-1:0] main_data;
    logic [DATA_WIDTH-1:0] main_data_d;
    logic                  skid_valid;
    logic                  skid_valid_d;
    logic [DATA_WIDTH-1:0] skid_data;
    logic [DATA_WIDTH-1:0] skid_data_d;

    fifo_axi_async #(
        .DATA_WIDTH (DATA_WIDTH),
        .DEPTH      (DEPTH)
    ) u_fifo (
        .i_axi_wr_aclk    (i_axi_wr_aclk),
        .i_axi_wr_aresetn (i_axi_wr_aresetn),
        .i_axi_rd_aclk    (i_axi_rd_aclk),
        .i_axi_rd_aresetn (i_axi_rd_aresetn),
        .i_wr_valid       (i_wr_valid),
        .o_wr_ready       (o_wr_ready),
        .i_wr_data        (i_wr_data),
        .i_rd_ready       (fifo_rd_ready),
        .o_rd_valid       (fifo_rd_valid),
        .o_rd_data        (fifo_rd_data),
        .o_wr_level       (o_wr_level)
    );

    assign fifo_take = fifo_rd_valid && fifo_rd_ready;
    assign out_take  = main_valid && i_rd_ready;

    // main is always the oldest entry, skid the next one
    always_comb begin
        main_valid_d = main_valid;
        main_data_d  = main_data;
        skid_valid_d = skid_valid;
        skid_data_d  = skid_data;
        if (out_take) begin
            if (skid_valid) begin
                main_data_d  = skid_data;  // skid moves up
                skid_valid_d = fifo_take;
                skid_data_d  = fifo_rd_data;
            end else begin
                main_valid_d = fifo_take;
                main_data_d  = fifo_rd_data;
            end
        end else if (!main_valid) begin
            main_valid_d = fifo_take;
            main_data_d  = fifo_rd_data;
        end else if (!skid_valid) begin
            skid_valid_d = fifo_take;
            skid_data_d  = fifo_rd_data;
        end
    end

    always_ff @(posedge i_axi_rd_aclk or negedge i_axi_rd_aresetn) begin
        if (!i_axi_rd_aresetn) begin
            main_valid    <= 1'b0;
            skid_valid    <= 1'b0;
            fifo_rd_ready <= 1'b0;
        end else begin
            main_valid    <= main_valid_d;
            skid_valid    <= skid_valid_d;
            fifo_rd_ready <= !(main_valid_d && skid_valid_d);  // request while a slot is free
        end
    end

    always_ff @(posedge i_axi_rd_aclk) begin
        main_data <= main_data_d;
        skid_data <= skid_data_d;
    end

    assign o_rd_valid = main_valid;
    assign o_rd_data  = main_data;

endmodule : axi_skid_buffer_async

`default_nettype wire

/* logic/cdc_stream_status.sv */
`default_nettype none

module cdc_stream_status #(
    parameter int ALMOST_FULL_LEVEL = 6
) (
    input  wire logic                                       i_axi_wr_aclk,
    input  wire logic                                       i_arst_n,  // write domain
    input  wire logic                                       i_wr_fire,
    input  wire logic [cdc_stream_pkg::CDC_LEVEL_WIDTH-1:0] i_wr_level,
    output logic      [cdc_stream_pkg::CDC_COUNT_WIDTH-1:0] o_wr_beats,
    output logic                                            o_almost_full
);

    import cdc_stream_pkg::*;

    localparam logic [CDC_LEVEL_WIDTH-1:0] AF_LEVEL = CDC_LEVEL_WIDTH'(ALMOST_FULL_LEVEL);

    // beat counter, wraps on overflow
    always_ff @(posedge i_axi_wr_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wr_beats <= '0;
        end else if (i_wr_fire) begin
            o_wr_beats <= o_wr_beats + 1'b1;
        end
    end

    // level lags reads by the pointer sync, so this errs toward high
    always_ff @(posedge i_axi_wr_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_almost_full <= 1'b0;
        end else begin
            o_almost_full <= (i_wr_level >= AF_LEVEL);
        end
    end

endmodule : cdc_stream_status

`default_nettype wire

/* logic/cdc_stream_top.sv */
`default_nettype none

module cdc_stream_top (
    input  wire logic                                       i_axi_wr_aclk,
    input  wire logic                                       i_axi_rd_aclk,
    input  wire logic                                       i_arst_n,

    // write side
    input  wire logic                                       i_wr_valid,
    output logic                                            o_wr_ready,
    input  wire logic [cdc_stream_pkg::CDC_DATA_WIDTH-1:0]  i_wr_data,

    // read side
    output logic                                            o_rd_valid,
    input  wire logic                                       i_rd_ready,
    output logic      [cdc_stream_pkg::CDC_DATA_WIDTH-1:0]  o_rd_data,

    // status, write domain
    output logic      [cdc_stream_pkg::CDC_COUNT_WIDTH-1:0] o_wr_beats,
    output logic                                            o_almost_full
);

    import cdc_stream_pkg::*;

    localparam int DATA_WIDTH        = CDC_DATA_WIDTH;
    localparam int DEPTH             = CDC_FIFO_DEPTH;
    localparam int ALMOST_FULL_LEVEL = 6;

    logic                       wr_rst_n;
    logic                       rd_rst_n;
    logic                       wr_fire;
    logic [CDC_LEVEL_WIDTH-1:0] wr_level;

    // async assert, release synchronized to each clock
    cdc_sync_bits #(
        .WIDTH  (1),
        .STAGES (CDC_SYNC_STAGES)
    ) u_wr_rst_sync (
        .i_clk    (i_axi_wr_aclk),
        .i_arst_n (i_arst_n),
        .i_d      (1'b1),
        .o_q      (wr_rst_n)
    );

    cdc_sync_bits #(
        .WIDTH  (1),
        .STAGES (CDC_SYNC_STAGES)
    ) u_rd_rst_sync (
        .i_clk    (i_axi_rd_aclk),
        .i_arst_n (i_arst_n),
        .i_d      (1'b1),
        .o_q      (rd_rst_n)
    );

    axi_skid_buffer_async #(
        .DATA_WIDTH (DATA_WIDTH),
        .DEPTH      (DEPTH)
    ) u_skid_buffer (
        .i_axi_wr_aclk    (i_axi_wr_aclk),
        .i_axi_wr_aresetn (wr_rst_n),
        .i_axi_rd_aclk    (i_axi_rd_aclk),
        .i_axi_rd_aresetn (rd_rst_n),
        .i_wr_valid       (i_wr_valid),
        .o_wr_ready       (o_wr_ready),
        .i_wr_data        (i_wr_data),
        .o_rd_valid       (o_rd_valid),
        .i_rd_ready       (i_rd_ready),
        .o_rd_data        (o_rd_data),
        .o_wr_level       (wr_level)
    );

    assign wr_fire = i_wr_valid && o_wr_ready;  // beat accepted this write edge

    cdc_stream_status #(
        .ALMOST_FULL_LEVEL (ALMOST_FULL_LEVEL)
    ) u_status (
        .i_axi_wr_aclk (i_axi_wr_aclk),
        .i_arst_n      (wr_rst_n),
        .i_wr_fire     (wr_fire),
        .i_wr_level    (wr_level),
        .o_wr_beats    (o_wr_beats),
        .o_almost_full (o_almost_full)
    );

endmodule : cdc_stream_top

`default_nettype wire

/* testbench/tb_cdc_stream.sv */
`default_nettype none

module tb_cdc_stream;

    import cdc_stream_pkg::*;

    localparam int WR_PERIOD     = 4;
    localparam int RD_PERIOD     = 6;
    localparam int DEPTH         = CDC_FIFO_DEPTH;
    localparam int N_RANDOM      = 400;
    localparam int PLANNED_BEATS = 2 + DEPTH + 1 + N_RANDOM;
    localparam int TIMEOUT       = PLANNED_BEATS * 20 * RD_PERIOD;

    // write driver modes
    localparam int WR_FILL   = 0;
    localparam int WR_RANDOM = 1;
    // read driver modes
    localparam int RD_STALL  = 0;
    localparam int RD_ALWAYS = 1;
    localparam int RD_RANDOM = 2;

    logic                       i_axi_wr_aclk = 1'b0;
    logic                       i_axi_rd_aclk = 1'b0;
    logic                       i_arst_n;
    logic                       i_wr_valid;
    logic                       o_wr_ready;
    logic [CDC_DATA_WIDTH-1:0]  i_wr_data;
    logic                       o_rd_valid;
    logic                       i_rd_ready;
    logic [CDC_DATA_WIDTH-1:0]  o_rd_data;
    logic [CDC_COUNT_WIDTH-1:0] o_wr_beats;
    logic                       o_almost_full;

    logic [CDC_DATA_WIDTH-1:0]  model_q[$];  // beats accepted, not yet read
    logic [CDC_COUNT_WIDTH-1:0] beats_model  = '0;
    logic [CDC_DATA_WIDTH-1:0]  rd_data_last = '0;
    logic                       rd_stall_last = 1'b0;
    logic                       wr_hs_last    = 1'b0;
    int                         wr_mode       = WR_FILL;
    int                         rd_mode       = RD_STALL;
    int                         wr_budget     = 0;  // beats still to offer
    int                         accepted      = 0;
    int                         read_count    = 0;
    int                         error_count   = 0;

    cdc_stream_top dut (
        .i_axi_wr_aclk (i_axi_wr_aclk),
        .i_axi_rd_aclk (i_axi_rd_aclk),
        .i_arst_n      (i_arst_n),
        .i_wr_valid    (i_wr_valid),
        .o_wr_ready    (o_wr_ready),
        .i_wr_data     (i_wr_data),
        .o_rd_valid    (o_rd_valid),
        .i_rd_ready    (i_rd_ready),
        .o_rd_data     (o_rd_data),
        .o_wr_beats    (o_wr_beats),
        .o_almost_full (o_almost_full)
    );

    initial begin : wr_clock
        forever #(WR_PERIOD / 2) i_axi_wr_aclk = ~i_axi_wr_aclk;
    end

    initial begin : rd_clock
        forever #(RD_PERIOD / 2) i_axi_rd_aclk = ~i_axi_rd_aclk;
    end

    task automatic mismatch_error(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        error_count++;
        $display("Fail %s: got 0x%h, expected 0x%h at time %0t", name, got, exp, $time);
    endtask

    task automatic protocol_error(input string msg);
        error_count++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    // outputs settled, inputs not yet changed
    task automatic step_wr_cycle();
        @(negedge i_axi_wr_aclk);
        #1;
    endtask

    // source holds a pending beat until it is taken
    initial begin : write_driver
        forever begin
            @(posedge i_axi_wr_aclk);
            #1;
            if (!(i_wr_valid && !wr_hs_last)) begin
                i_wr_data = $urandom;
                if (wr_budget == 0) begin
                    i_wr_valid = 1'b0;
                end else if (wr_mode == WR_FILL) begin
                    i_wr_valid = 1'b1;
                end else begin
                    i_wr_valid = ($urandom_range(99) < 70);
                end
            end
        end
    end

    initial begin : read_driver
        forever begin
            @(posedge i_axi_rd_aclk);
            #1;
            case (rd_mode)
                RD_STALL:  i_rd_ready = 1'b0;
                RD_ALWAYS: i_rd_ready = 1'b1;
                default:   i_rd_ready = ($urandom_range(99) < 50);
            endcase
        end
    end

    // negedge sees what the next rising edge will take
    initial begin : write_monitor
        forever begin
            @(negedge i_axi_wr_aclk);
            assert (o_wr_beats == beats_model)
                else mismatch_error("o_wr_beats", 32'(o_wr_beats), 32'(beats_model));
            wr_hs_last = i_wr_valid && o_wr_ready;
            if (wr_hs_last) begin
                model_q.push_back(i_wr_data);
                accepted++;
                beats_model++;
                if (wr_budget > 0) begin
                    wr_budget--;
                end
            end
        end
    end

    initial begin : read_monitor
        logic [CDC_DATA_WIDTH-1:0] exp_data;
        forever begin
            @(negedge i_axi_rd_aclk);
            if (o_rd_valid) begin
                assert (model_q.size() > 0)
                    else protocol_error("o_rd_valid high with no beat outstanding");
            end
            if (rd_stall_last) begin  // held beat must not move
                assert (o_rd_valid)
                    else protocol_error("o_rd_valid dropped while i_rd_ready was low");
                assert (o_rd_data == rd_data_last)
                    else mismatch_error("o_rd_data (stalled)", o_rd_data, rd_data_last);
            end
            if (o_rd_valid && i_rd_ready) begin
                read_count++;  // every beat the DUT hands out
                if (model_q.size() > 0) begin
                    exp_data = model_q.pop_front();
                    assert (o_rd_data == exp_data)
                        else mismatch_error("o_rd_data", o_rd_data, exp_data);
                end
            end
            rd_stall_last = o_rd_valid && !i_rd_ready;
            rd_data_last  = o_rd_data;
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main_sequence
        int wait_cnt;
        void'($urandom(32'h6908));
        i_arst_n   = 1'b0;
        i_wr_valid = 1'b0;
        i_wr_data  = '0;
        i_rd_ready = 1'b0;

        repeat (5) @(posedge i_axi_wr_aclk);
        #1;
        assert (!o_wr_ready) else mismatch_error("o_wr_ready", 32'(o_wr_ready), 32'h0);
        assert (!o_rd_valid) else mismatch_error("o_rd_valid", 32'(o_rd_valid), 32'h0);
        assert (!o_almost_full)
            else mismatch_error("o_almost_full", 32'(o_almost_full), 32'h0);
        assert (o_wr_beats == '0) else mismatch_error("o_wr_beats", 32'(o_wr_beats), 32'h0);
        i_arst_n = 1'b1;

        wait_cnt = 0;
        while (!o_wr_ready && wait_cnt < 10) begin
            step_wr_cycle();
            wait_cnt++;
        end
        assert (o_wr_ready) else protocol_error("o_wr_ready did not rise after reset");

        // two beats first, so the skid stage is full before the fifo fills
        wr_mode   = WR_FILL;
        wr_budget = 2;
        wait_cnt  = 0;
        while (wr_budget != 0 && wait_cnt < 100) begin
            step_wr_cycle();
            wait_cnt++;
        end
        assert (wr_budget == 0) else protocol_error("priming beats were not accepted");
        repeat (20) step_wr_cycle();

        wr_budget = DEPTH + 1;  // one beat left pending at full
        wait_cnt  = 0;
        while (o_wr_ready && wait_cnt < 200) begin
            step_wr_cycle();
            wait_cnt++;
        end
        assert (!o_wr_ready) else protocol_error("o_wr_ready never fell with reads stalled");
        assert (accepted == DEPTH + 2)
            else mismatch_error("beats accepted at o_wr_ready fall", accepted, DEPTH + 2);

        repeat (30) begin
            step_wr_cycle();
            assert (!o_wr_ready) else protocol_error("o_wr_ready rose while reads were stalled");
            assert (o_almost_full)
                else mismatch_error("o_almost_full", 32'(o_almost_full), 32'h1);
        end

        // drain everything, then nothing moves
        rd_mode  = RD_ALWAYS;
        wait_cnt = 0;
        while ((wr_budget != 0 || model_q.size() != 0) && wait_cnt < 300) begin
            step_wr_cycle();
            wait_cnt++;
        end
        assert (model_q.size() == 0) else protocol_error("fifo did not drain");
        wait_cnt = 0;
        while (o_almost_full && wait_cnt < 10) begin
            step_wr_cycle();
            wait_cnt++;
        end
        assert (!o_almost_full)
            else mismatch_error("o_almost_full", 32'(o_almost_full), 32'h0);
        assert (o_wr_ready) else protocol_error("o_wr_ready stayed low after the drain");

        wr_mode   = WR_RANDOM;
        rd_mode   = RD_RANDOM;
        wr_budget = N_RANDOM;
        while (wr_budget != 0 || model_q.size() != 0) begin
            step_wr_cycle();
        end
        repeat (10) step_wr_cycle();
        assert (read_count == accepted)
            else mismatch_error("beats read", read_count, accepted);

        $display("errors=%0d beats accepted=%0d beats read=%0d",
                 error_count, accepted, read_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_cdc_stream

`default_nettype wire

/* cdc_stream_top.f */
logic/cdc_stream_pkg.sv
logic/cdc_sync_bits.sv
logic/fifo_axi_async.sv
logic/axi_skid_buffer_async.sv
logic/cdc_stream_status.sv
logic/cdc_stream_top.sv
testbench/tb_cdc_stream.sv
